// ==== build.f ====
+incdir+.
core_pkg.sv
word_queue.sv
uop_decoder.sv
issue_scoreboard.sv
regfile.sv
alu_exec_stage.sv
result_port.sv
alu_core_top.sv
tb_alu_core_assert.sv
tb_alu_core.sv

// ==== run.sh ====
#!/bin/sh
# builds the ALU back end testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_alu_core \
    -Mdir obj_dir -o sim_alu_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_alu_core > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation failed" "$log"; then
    echo "failure reported in $log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "run clean"
exit 0

// ==== tb_alu_core.sv ====
// testbench for the ALU back end, random words from an LFSR checked against a register model
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_alu_core
    import core_pkg::*;
();

    localparam int timeout_cycles = `NUM_INSTR * 20;

    logic     clk;
    logic     rst;
    logic     in_valid;
    word_t    in_word;
    logic     in_credit;
    logic     result_valid;
    reg_idx_t result_rd;
    word_t    result_data;
    logic     out_credit;

    logic [15:0] lfsr;
    word_t       arch_regs [32];
    reg_idx_t    exp_rd [$];
    word_t       exp_data [$];
    int          credit_return_at [$];
    reg_idx_t    last_rd;
    int          cycle;
    int          send_credits;
    int          words_sent;
    int          results_expected;
    int          results_seen;
    int          credits_returned;
    int          idle_cycles;
    logic        withhold;
    logic        drained;
    string       phase;

    alu_core_top alu_core_top_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_word      (in_word),
        .in_credit    (in_credit),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data),
        .out_credit   (out_credit)
    );

    bind result_port tb_alu_core_assert tb_alu_core_assert_i (
        .clk          (clk),
        .rst          (rst),
        .out_credit   (out_credit),
        .credit_cnt   (credit_cnt),
        .result_valid (result_valid),
        .result_data  (result_data)
    );

    always #5 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (act !== exp) begin
            report_failure($sformatf("CHECK FAILED %s expected x%0d actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            report_failure($sformatf("CHECK FAILED %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            report_failure($sformatf("CHECK FAILED %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    // x16 + x14 + x13 + x11 + 1, one step per bit taken
    function automatic int take_bits(input int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    function automatic logic [6:0] unsupported_opcode(input logic [2:0] sel);
        case (sel)
            3'd0: return 7'b0000011;
            3'd1: return 7'b0100011;
            3'd2: return 7'b1100011;
            3'd3: return 7'b1101111;
            3'd4: return 7'b1100111;
            3'd5: return 7'b0010111;
            3'd6: return 7'b1110011;
            default: return 7'b0001111;
        endcase
    endfunction

    // registers limited to x0..x7, rs1 often reuses the last rd
    function automatic word_t build_word();
        int          kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  funct7;
        kind = take_bits(4);
        rd   = reg_idx_t'(take_bits(3));
        if (take_bits(1) != 0) begin
            rs1 = last_rd;
        end else begin
            rs1 = reg_idx_t'(take_bits(3));
        end
        rs2     = reg_idx_t'(take_bits(3));
        f3      = 3'(take_bits(3));
        imm     = 12'(take_bits(12));
        last_rd = rd;
        if (kind < 6) begin
            if (f3 == 3'b001) begin
                imm[11:5] = 7'b0;
            end else if (f3 == 3'b101) begin
                imm[11:5] = imm[11] ? 7'b0100000 : 7'b0;
            end
            return {imm, rs1, f3, rd, 7'b0010011};
        end else if (kind < 11) begin
            funct7 = (imm[0] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
            return {funct7, rs2, rs1, f3, rd, 7'b0110011};
        end else if (kind < 14) begin
            return {imm, rs1, f3, rd, 7'b0110111};
        end
        return {imm, rs1, f3, rd, unsupported_opcode(3'(take_bits(3)))};
    endfunction

    // architectural effect of one word, queued as the expected result
    task automatic model_execute(input word_t w);
        logic [2:0] f3;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      res;
        logic [4:0] sh;
        logic       writes;
        f3     = w[14:12];
        rd     = w[11:7];
        a      = arch_regs[w[19:15]];
        b      = w[5] ? arch_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh     = b[4:0];
        res    = '0;
        writes = 1'b1;
        if (w[6:0] == 7'b0110111) begin
            res = {w[31:12], 12'h000};
        end else if (w[6:0] == 7'b0010011 || w[6:0] == 7'b0110011) begin
            case (f3)
                3'b000: res = (w[5] && w[30]) ? a - b : a + b;
                3'b001: res = a << sh;
                3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011: res = (a < b) ? 32'd1 : 32'd0;
                3'b100: res = a ^ b;
                3'b101: begin
                    if (w[30]) begin
                        res = $signed(a) >>> sh;
                    end else begin
                        res = a >> sh;
                    end
                end
                3'b110: res = a | b;
                3'b111: res = a & b;
            endcase
        end else begin
            writes = 1'b0;
        end
        if (writes && rd != '0) begin
            arch_regs[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
            results_expected++;
        end
    endtask

    task automatic take_result();
        reg_idx_t rd_want;
        word_t    data_want;
        string    name;
        results_seen++;
        if (exp_rd.size() == 0) begin
            report_failure("a result appeared that no sent word should produce");
        end
        rd_want   = exp_rd.pop_front();
        data_want = exp_data.pop_front();
        name      = $sformatf("%s result %0d", phase, results_seen);
        check_reg_idx({name, " rd"}, rd_want, result_rd);
        check_word({name, " data"}, data_want, result_data);
        credit_return_at.push_back(cycle + 1 + take_bits(3));
        if (results_seen - credits_returned > `OUT_CREDITS) begin
            report_failure("more results outstanding than the core has output credits");
        end
    endtask

    // outputs are sampled at the edge before the NBA updates, inputs driven after
    task automatic run_cycle();
        word_t w;
        cycle++;
        idle_cycles++;
        if (cycle > timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles with %0d results pending",
                                     cycle, exp_rd.size()));
        end
        if (cycle <= 2 && (in_credit || result_valid)) begin
            report_failure("in_credit or result_valid went high right after reset");
        end
        if (in_credit) begin
            send_credits++;
            idle_cycles = 0;
        end
        if (send_credits > `IQ_DEPTH) begin
            report_failure("more in_credit pulses came back than words were sent");
        end
        if (result_valid) begin
            take_result();
            idle_cycles = 0;
        end

        // consumer sits on its credits for part of every 1000 cycles
        withhold = (cycle % 1000) >= 700 && (cycle % 1000) < 900;
        if (withhold) begin
            phase = "credit_withhold";
        end else if (words_sent < `NUM_INSTR) begin
            phase = "alu_stream";
        end else begin
            phase = "drain";
        end
        if (!withhold && credit_return_at.size() > 0 && credit_return_at[0] <= cycle) begin
            out_credit <= 1'b1;
            void'(credit_return_at.pop_front());
            credits_returned++;
        end else begin
            out_credit <= 1'b0;
        end

        if (words_sent < `NUM_INSTR && send_credits > 0 && take_bits(2) != 0) begin
            w = build_word();
            model_execute(w);
            in_valid <= 1'b1;
            in_word  <= w;
            words_sent++;
            send_credits--;
            idle_cycles = 0;
        end else begin
            in_valid <= 1'b0;
        end
        drained = words_sent == `NUM_INSTR && exp_rd.size() == 0 &&
                  credit_return_at.size() == 0 && idle_cycles >= 20;
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        in_valid         = 1'b0;
        in_word          = '0;
        out_credit       = 1'b0;
        lfsr             = 16'd38922;
        last_rd          = '0;
        cycle            = 0;
        send_credits     = `IQ_DEPTH;
        words_sent       = 0;
        results_expected = 0;
        results_seen     = 0;
        credits_returned = 0;
        idle_cycles      = 0;
        withhold         = 1'b0;
        drained          = 1'b0;
        phase            = "reset";
        for (int i = 0; i < 32; i++) begin
            arch_regs[i] = '0;
        end

        // first edge only loads the reset values
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            if (i > 0 && (in_credit !== 1'b0 || result_valid !== 1'b0)) begin
                report_failure("in_credit or result_valid went high during reset");
            end
        end
        rst <= 1'b0;

        while (!drained) begin
            @(posedge clk);
            run_cycle();
        end

        check_count("drain sender credits", `IQ_DEPTH, send_credits);
        check_count("drain result count", results_expected, results_seen);
        $display("Simulation passed");
        $finish;
    end

endmodule : tb_alu_core

// ==== tb_alu_core_assert.sv ====
// concurrent checks on the result port, bound into result_port by the testbench
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_alu_core_assert
    import core_pkg::*;
(
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 out_credit,
    input logic [$clog2(`OUT_CREDITS + 1)-1:0] credit_cnt,
    input logic                                 result_valid,
    input word_t                                result_data
);

    localparam int cnt_w = $clog2(`OUT_CREDITS + 1);
    localparam logic [cnt_w-1:0] max_credits = cnt_w'(`OUT_CREDITS);

    // results shown that the consumer has not paid back yet
    int unpaid;

    always_ff @(posedge clk) begin
        if (rst) begin
            unpaid <= 0;
        end else begin
            unpaid <= unpaid + int'(result_valid) - int'(out_credit);
        end
    end

    // never more credits than the consumer handed out
    credit_max: assert property (@(posedge clk) disable iff (rst) credit_cnt <= max_credits)
        else $error("output credit counter above its reset value");

    // every result needs a credit the consumer still had out
    result_paid: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> unpaid < `OUT_CREDITS)
        else $error("result shown with every output credit already used");

    data_known: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> !$isunknown(result_data))
        else $error("result data unknown while result_valid is high");

endmodule : tb_alu_core_assert

// ==== alu_core_top.sv ====
// top of the ALU back end, word queue in, decode and issue, execute, then the result port out
`timescale 1ns/1ps
`include "core_defines.svh"

module alu_core_top
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  word_t    in_word,
    output logic     in_credit,
    output logic     result_valid,
    output reg_idx_t result_rd,
    output word_t    result_data,
    input  logic     out_credit
);

    logic     head_valid;
    word_t    head_word;
    uop_t     uop;
    logic     uop_valid;
    logic     discard;
    logic     issue;
    logic     pop;
    word_t    rs1_data;
    word_t    rs2_data;
    logic     ex_valid;
    reg_idx_t ex_rd;
    word_t    ex_result;
    logic     credit_avail;

    // discarded words leave the queue without issuing
    assign pop = issue | discard;

    word_queue word_queue_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_word    (in_word),
        .pop        (pop),
        .head_valid (head_valid),
        .head_word  (head_word),
        .in_credit  (in_credit)
    );

    uop_decoder uop_decoder_i (
        .head_valid (head_valid),
        .head_word  (head_word),
        .uop        (uop),
        .uop_valid  (uop_valid),
        .discard    (discard)
    );

    issue_scoreboard issue_scoreboard_i (
        .clk          (clk),
        .rst          (rst),
        .uop          (uop),
        .uop_valid    (uop_valid),
        .credit_avail (credit_avail),
        .wb_valid     (result_valid),
        .wb_rd        (result_rd),
        .issue        (issue)
    );

    regfile regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1      (uop.rs1),
        .rs2      (uop.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (result_valid),
        .wd_rd    (result_rd),
        .wd_data  (result_data)
    );

    alu_exec_stage alu_exec_stage_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .uop       (uop),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .ex_valid  (ex_valid),
        .ex_rd     (ex_rd),
        .ex_result (ex_result)
    );

    result_port result_port_i (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .out_credit   (out_credit),
        .credit_avail (credit_avail),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

endmodule : alu_core_top

// ==== result_port.sv ====
// writeback register that drives the result port and register write, plus the output credits
`timescale 1ns/1ps
`include "core_defines.svh"

module result_port
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  word_t    ex_result,
    input  logic     out_credit,
    output logic     credit_avail,
    output logic     result_valid,
    output reg_idx_t result_rd,
    output word_t    result_data
);

    localparam int cnt_w = $clog2(`OUT_CREDITS + 1);

    logic [cnt_w-1:0] credit_cnt;

    assign credit_avail = credit_cnt != '0;

    // a credit is spent at issue, two cycles ahead of the result
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= cnt_w'(`OUT_CREDITS);
        end else begin
            credit_cnt <= credit_cnt - cnt_w'(issue) + cnt_w'(out_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            result_rd   <= ex_rd;
            result_data <= ex_result;
        end
    end

endmodule : result_port

// ==== alu_exec_stage.sv ====
// execute stage, registers the selected operands at issue and computes the ALU result
`timescale 1ns/1ps

module alu_exec_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     issue,
    input  uop_t     uop,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     ex_valid,
    output reg_idx_t ex_rd,
    output word_t    ex_result
);

    word_t     opr1_is;
    word_t     opr2_is;
    word_t     opr1_ex;
    word_t     opr2_ex;
    alu_func_t func_ex;
    logic [4:0] shamt;

    // lui takes zero in place of rs1
    assign opr1_is = uop.clear_rs1 ? '0 : rs1_data;
    assign opr2_is = (uop.opr2_sel == opr2_imm) ? uop.imm : rs2_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            func_ex <= uop.func;
            ex_rd   <= uop.rd;
            opr1_ex <= opr1_is;
            opr2_ex <= opr2_is;
        end
    end

    assign shamt = opr2_ex[4:0];

    always_comb begin
        unique case (func_ex)
            alu_add:  ex_result = opr1_ex + opr2_ex;
            alu_sub:  ex_result = opr1_ex - opr2_ex;
            alu_sll:  ex_result = opr1_ex << shamt;
            alu_slt:  ex_result = word_t'($signed(opr1_ex) < $signed(opr2_ex));
            alu_sltu: ex_result = word_t'(opr1_ex < opr2_ex);
            alu_xor:  ex_result = opr1_ex ^ opr2_ex;
            alu_srl:  ex_result = opr1_ex >> shamt;
            alu_sra:  ex_result = word_t'($signed(opr1_ex) >>> shamt);
            alu_or:   ex_result = opr1_ex | opr2_ex;
            alu_and:  ex_result = opr1_ex & opr2_ex;
            default:  ex_result = opr2_ex;
        endcase
    end

endmodule : alu_exec_stage

// ==== regfile.sv ====
// architectural integer register file, two combinational reads and one write from writeback
`timescale 1ns/1ps

module regfile
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t wd_rd,
    input  word_t    wd_data
);

    localparam int num_regs = 2 ** $bits(reg_idx_t);

    word_t regs [num_regs];

    // x0 reads zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_rd != '0) begin
            regs[wd_rd] <= wd_data;
        end
    end

endmodule : regfile

// ==== issue_scoreboard.sv ====
// register busy tracking and the issue decision for the op at the queue head
`timescale 1ns/1ps

module issue_scoreboard
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  uop_t     uop,
    input  logic     uop_valid,
    input  logic     credit_avail,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    output logic     issue
);

    localparam int num_regs = 2 ** $bits(reg_idx_t);

    logic [num_regs-1:0] busy;
    logic                rs1_hazard;
    logic                rs2_hazard;
    logic                rd_hazard;

    // x0 is never marked busy, so an x0 source never stalls
    assign rs1_hazard = uop.has_rs1 & busy[uop.rs1];
    assign rs2_hazard = uop.has_rs2 & busy[uop.rs2];

    // waiting on rd keeps results in order and avoids WAW
    assign rd_hazard = busy[uop.rd];

    assign issue = uop_valid & ~rs1_hazard & ~rs2_hazard & ~rd_hazard & credit_avail;

    // set and clear never hit the same register in one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (issue) begin
                busy[uop.rd] <= 1'b1;
            end
            if (wb_valid) begin
                busy[wb_rd] <= 1'b0;
            end
        end
    end

endmodule : issue_scoreboard

// ==== uop_decoder.sv ====
// combinational decode of the queue head word into an ALU micro-op, or a discard request
`timescale 1ns/1ps

module uop_decoder
    import core_pkg::*;
(
    input  logic  head_valid,
    input  word_t head_word,
    output uop_t  uop,
    output logic  uop_valid,
    output logic  discard
);

    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    logic       alt;

    assign opcode = head_word[6:0];
    assign funct3 = head_word[14:12];
    assign funct7 = head_word[31:25];

    // bit 30 selects sub and sra
    assign alt = funct7 == 7'b0100000;

    always_comb begin
        uop.func      = alu_pass;
        uop.opr2_sel  = opr2_rs2;
        uop.rd        = head_word[11:7];
        uop.rs1       = head_word[19:15];
        uop.rs2       = head_word[24:20];
        uop.has_rs1   = 1'b0;
        uop.has_rs2   = 1'b0;
        uop.clear_rs1 = 1'b0;
        uop.imm       = {{20{head_word[31]}}, head_word[31:20]};
        supported     = 1'b0;

        unique case (opcode)
            opc_op_imm: begin
                uop.has_rs1  = 1'b1;
                uop.opr2_sel = opr2_imm;
                supported    = 1'b1;
                unique case (funct3)
                    3'b000: uop.func = alu_add;
                    3'b010: uop.func = alu_slt;
                    3'b011: uop.func = alu_sltu;
                    3'b100: uop.func = alu_xor;
                    3'b110: uop.func = alu_or;
                    3'b111: uop.func = alu_and;
                    3'b001: begin
                        uop.func  = alu_sll;
                        supported = funct7 == 7'b0;
                    end
                    3'b101: begin
                        uop.func  = alt ? alu_sra : alu_srl;
                        supported = (funct7 == 7'b0) || alt;
                    end
                endcase
            end
            opc_op: begin
                uop.has_rs1 = 1'b1;
                uop.has_rs2 = 1'b1;
                // alt encodings exist only for add/sub and the right shifts
                supported = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
                unique case (funct3)
                    3'b000: uop.func = alt ? alu_sub : alu_add;
                    3'b001: uop.func = alu_sll;
                    3'b010: uop.func = alu_slt;
                    3'b011: uop.func = alu_sltu;
                    3'b100: uop.func = alu_xor;
                    3'b101: uop.func = alt ? alu_sra : alu_srl;
                    3'b110: uop.func = alu_or;
                    3'b111: uop.func = alu_and;
                endcase
            end
            opc_lui: begin
                uop.func      = alu_add;
                uop.opr2_sel  = opr2_imm;
                uop.clear_rs1 = 1'b1;
                uop.imm       = {head_word[31:12], 12'b0};
                supported     = 1'b1;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // writes to x0 have no visible effect, drop them here
    assign uop_valid = head_valid & supported & (uop.rd != '0);
    assign discard   = head_valid & ~(supported & (uop.rd != '0));

endmodule : uop_decoder

// ==== word_queue.sv ====
// input FIFO of raw instruction words, pops feed decode and each pop returns one sender credit
`timescale 1ns/1ps
`include "core_defines.svh"

module word_queue
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    input  word_t in_word,
    input  logic  pop,
    output logic  head_valid,
    output word_t head_word,
    output logic  in_credit
);

    localparam int depth = `IQ_DEPTH;
    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    word_t            mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_pop;

    assign head_valid = count != '0;
    assign head_word  = mem[rd_ptr];
    assign do_pop     = pop & head_valid;

    // one credit back per word leaving, issued or discarded
    assign in_credit = do_pop;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_word;
        end
    end

    // sender credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(in_valid) - cnt_w'(do_pop);
        end
    end

endmodule : word_queue

// ==== core_pkg.sv ====
// shared data types for the ALU back end, pulled into each module by a wildcard import
`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // alu_pass forwards the second operand unchanged
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass
    } alu_func_t;

    // source of the second ALU operand
    typedef enum logic {
        opr2_rs2,
        opr2_imm
    } opr2_sel_t;

    // decoded ALU micro-op
    typedef struct packed {
        alu_func_t func;
        opr2_sel_t opr2_sel;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        logic      has_rs1;
        logic      has_rs2;
        logic      clear_rs1;  // lui, first operand forced to zero
        word_t     imm;
    } uop_t;

endpackage : core_pkg

// ==== core_defines.svh ====
// global sizing macros for the integer ALU back end, included by the package, RTL and testbench
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data word width
`define XLEN 32

// register index width, 32 architectural registers
`define REG_IDX_W 5

// word queue entries, also the credits a sender starts with
`define IQ_DEPTH 8

// result credits held by the core after reset
`define OUT_CREDITS 4

// instruction words sent in one test run
`define NUM_INSTR 2000

`endif
